/* cmd_pkg.sv */
package cmd_pkg;

  localparam int data_width  = 32;                        // AXI data and accumulator width
  localparam int addr_width  = 16;                        // AXI address width
  localparam int num_regs    = 4;                         // Accumulator count
  localparam int seq_width   = 4;                         // Rolling sequence number
  localparam int idx_width   = 2;                         // Register index field
  localparam int imm_width   = 16;                        // Raw immediate in the command word
  localparam int tuser_width = seq_width + idx_width + 2; // seq, reg_idx, status

  // Command opcodes in bits 31..28, codes 8 to 15 are illegal
  typedef enum logic [3:0] {
    op_nop  = 4'd0, // No result
    op_load = 4'd1, // reg = imm
    op_add  = 4'd2, // reg = reg + imm
    op_sub  = 4'd3, // reg = reg - imm
    op_and  = 4'd4, // reg = reg & imm
    op_xor  = 4'd5, // reg = reg ^ imm
    op_shl  = 4'd6, // reg = reg << imm[4:0]
    op_read = 4'd7  // Report reg unchanged
  } opcode_e;

  typedef enum logic [1:0] {
    st_ok      = 2'd0,
    st_illegal = 2'd1
  } status_e;

  typedef struct packed {
    opcode_e                opcode;   // 31..28
    logic [idx_width-1:0]   reg_idx;  // 27..26
    logic [9:0]             reserved; // 25..16, ignored
    logic [imm_width-1:0]   imm;      // 15..0
  } cmd_word_t;

  typedef struct packed {
    logic                   valid;
    opcode_e                opcode;
    logic [idx_width-1:0]   reg_idx;
    logic [data_width-1:0]  imm32;    // Zero-extended immediate
    logic                   illegal;
  } decoded_t;

  typedef struct packed {
    logic                   valid;
    logic [data_width-1:0]  value;
    logic [seq_width-1:0]   seq;      // Filled in by the result stage
    logic [idx_width-1:0]   reg_idx;
    status_e                status;
  } result_t;

endpackage

/* axi_axis_writer.sv */
`timescale 1ns/10ps

module axi_axis_writer (
  input  logic                          aclk,
  input  logic                          aresetn,

  // AXI4-Lite write side
  input  logic [cmd_pkg::addr_width-1:0] s_axi_awaddr,  // Ignored, only data matters
  input  logic                          s_axi_awvalid,
  output logic                          s_axi_awready,
  input  logic [cmd_pkg::data_width-1:0] s_axi_wdata,
  input  logic                          s_axi_wvalid,
  output logic                          s_axi_wready,
  output logic [1:0]                    s_axi_bresp,
  output logic                          s_axi_bvalid,
  input  logic                          s_axi_bready,

  // AXI4-Lite read side, tied off
  input  logic [cmd_pkg::addr_width-1:0] s_axi_araddr,
  input  logic                          s_axi_arvalid,
  output logic                          s_axi_arready,
  output logic [cmd_pkg::data_width-1:0] s_axi_rdata,
  output logic [1:0]                    s_axi_rresp,
  output logic                          s_axi_rvalid,
  input  logic                          s_axi_rready,

  // Command stream
  output logic [cmd_pkg::data_width-1:0] m_axis_tdata,
  output logic                          m_axis_tvalid
);

  logic bvalid_q; // Response pending, blocks new writes
  logic accept;   // Both channels valid and no response outstanding

  assign accept = s_axi_awvalid & s_axi_wvalid & ~bvalid_q;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      bvalid_q <= 1'b0;
    end
    else if (accept)
    begin
      bvalid_q <= 1'b1;                   // Response follows in the next cycle
    end
    else if (bvalid_q && s_axi_bready)
    begin
      bvalid_q <= 1'b0;                   // Host took the response
    end
  end

  assign s_axi_awready = accept;           // Address and data taken together
  assign s_axi_wready  = accept;
  assign s_axi_bresp   = 2'b00;            // Always OKAY
  assign s_axi_bvalid  = bvalid_q;

  assign s_axi_arready = 1'b0;             // No read path
  assign s_axi_rdata   = '0;
  assign s_axi_rresp   = 2'b00;
  assign s_axi_rvalid  = 1'b0;

  assign m_axis_tdata  = s_axi_wdata;      // Word passes straight through
  assign m_axis_tvalid = accept;           // One pulse per accepted write

endmodule

/* cmd_decode.sv */
`timescale 1ns/10ps

module cmd_decode (
  input  logic               aclk,
  input  logic               aresetn,
  input  cmd_pkg::cmd_word_t cmd_tdata,  // Raw command word from the writer
  input  logic               cmd_tvalid, // One cycle per accepted write
  output cmd_pkg::decoded_t  dec         // Registered decoded operation
);

  import cmd_pkg::*;

  logic [data_width-1:0] imm_ext;   // Zero-extended immediate
  logic                  is_illegal;

  // Upper half of the opcode space is unassigned
  assign is_illegal = (cmd_tdata.opcode > op_read);

  assign imm_ext = {{(data_width-imm_width){1'b0}}, cmd_tdata.imm};

  // Fields load on each strobe and valid follows the strobe one cycle later
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      dec.valid <= 1'b0;
    end
    else
    begin
      dec.valid <= cmd_tvalid;            // Single-cycle strobe at T+1
      if (cmd_tvalid)
      begin
        dec.opcode  <= cmd_tdata.opcode;  // Raw code kept even when illegal
        dec.reg_idx <= cmd_tdata.reg_idx;
        dec.imm32   <= imm_ext;
        dec.illegal <= is_illegal;
      end
    end
  end

endmodule

/* accum_execute.sv */
`timescale 1ns/10ps

module accum_execute (
  input  logic              aclk,
  input  logic              aresetn,
  input  cmd_pkg::decoded_t dec,      // Decoded operation, valid at T+1
  output cmd_pkg::result_t  exec_res  // Result of the operation, valid at T+2
);

  import cmd_pkg::*;

  logic [data_width-1:0] acc_q [num_regs]; // Accumulator array
  logic [data_width-1:0] cur_val;          // Indexed register before the op
  logic [data_width-1:0] new_val;          // Value after the op, also the reported one
  logic [4:0]            shamt;            // Shift amount from the immediate
  logic                  writes_reg;       // Opcode modifies the register

  always_comb
  begin
    cur_val    = acc_q[dec.reg_idx];
    shamt      = dec.imm32[4:0];
    new_val    = cur_val;                  // Read, nop and illegal leave it as is
    writes_reg = 1'b0;
    if (!dec.illegal)
    begin
      writes_reg = 1'b1;
      case (dec.opcode)
        op_load: new_val = dec.imm32;
        op_add:  new_val = cur_val + dec.imm32;   // Modulo 2^32
        op_sub:  new_val = cur_val - dec.imm32;   // Wraps below zero
        op_and:  new_val = cur_val & dec.imm32;
        op_xor:  new_val = cur_val ^ dec.imm32;
        op_shl:  new_val = cur_val << shamt;
        default: writes_reg = 1'b0;               // op_nop and op_read
      endcase
    end
  end

  // Accumulators and result valid clear on reset
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      for (int i = 0; i < num_regs; i++)
      begin
        acc_q[i] <= '0;
      end
      exec_res.valid <= 1'b0;
    end
    else
    begin
      if (dec.valid && writes_reg)
      begin
        acc_q[dec.reg_idx] <= new_val;            // Update lands at T+2
      end
      exec_res.valid <= dec.valid && (dec.opcode != op_nop);
      if (dec.valid)
      begin
        exec_res.value   <= new_val;
        exec_res.seq     <= '0;                   // Numbered downstream
        exec_res.reg_idx <= dec.reg_idx;
        exec_res.status  <= dec.illegal ? st_illegal : st_ok;
      end
    end
  end

endmodule

/* result_pack.sv */
`timescale 1ns/10ps

module result_pack (
  input  logic                            aclk,
  input  logic                            aresetn,
  input  cmd_pkg::result_t                exec_res,   // Executed result, no seq yet
  output logic [cmd_pkg::data_width-1:0]  res_tdata,  // Register value
  output logic [cmd_pkg::tuser_width-1:0] res_tuser,  // {seq, reg_idx, status}
  output logic                            res_tvalid  // One pulse per result at T+3
);

  import cmd_pkg::*;

  logic [seq_width-1:0] seq_q; // Number for the next emitted result
  result_t              out_q; // Output register with seq filled in

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      seq_q       <= '0;
      out_q.valid <= 1'b0;
    end
    else
    begin
      out_q.valid <= exec_res.valid;
      if (exec_res.valid)
      begin
        out_q.value   <= exec_res.value;
        out_q.reg_idx <= exec_res.reg_idx;
        out_q.status  <= exec_res.status;
        out_q.seq     <= seq_q;            // Stamp current number
        seq_q         <= seq_q + 1'b1;     // Wraps 15 to 0
      end
    end
  end

  assign res_tdata  = out_q.value;
  assign res_tuser  = {out_q.seq, out_q.reg_idx, out_q.status};
  assign res_tvalid = out_q.valid;

endmodule

/* cmd_engine_top.sv */
`timescale 1ns/10ps

module cmd_engine_top (
  input  logic                            aclk,
  input  logic                            aresetn,

  // Host write port
  input  logic [cmd_pkg::addr_width-1:0]  s_axi_awaddr,
  input  logic                            s_axi_awvalid,
  output logic                            s_axi_awready,
  input  logic [cmd_pkg::data_width-1:0]  s_axi_wdata,
  input  logic                            s_axi_wvalid,
  output logic                            s_axi_wready,
  output logic [1:0]                      s_axi_bresp,
  output logic                            s_axi_bvalid,
  input  logic                            s_axi_bready,

  // Host read port, unused
  input  logic [cmd_pkg::addr_width-1:0]  s_axi_araddr,
  input  logic                            s_axi_arvalid,
  output logic                            s_axi_arready,
  output logic [cmd_pkg::data_width-1:0]  s_axi_rdata,
  output logic [1:0]                      s_axi_rresp,
  output logic                            s_axi_rvalid,
  input  logic                            s_axi_rready,

  // Result stream, consumer always ready
  output logic [cmd_pkg::data_width-1:0]  res_tdata,
  output logic [cmd_pkg::tuser_width-1:0] res_tuser,
  output logic                            res_tvalid
);

  import cmd_pkg::*;

  cmd_word_t cmd_tdata;  // Accepted command word
  logic      cmd_tvalid; // Acceptance strobe at T
  decoded_t  dec;        // Decoded op at T+1
  result_t   exec_res;   // Executed op at T+2

  axi_axis_writer u_writer (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .m_axis_tdata  (cmd_tdata),
    .m_axis_tvalid (cmd_tvalid)
  );

  cmd_decode u_decode (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .cmd_tdata  (cmd_tdata),
    .cmd_tvalid (cmd_tvalid),
    .dec        (dec)
  );

  accum_execute u_execute (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .dec      (dec),
    .exec_res (exec_res)
  );

  result_pack u_result (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .exec_res   (exec_res),
    .res_tdata  (res_tdata),
    .res_tuser  (res_tuser),
    .res_tvalid (res_tvalid)
  );

endmodule

/* tb_cmd_engine.sv */
`timescale 1ns/10ps

module tb_cmd_engine;

  import cmd_pkg::*;

  typedef struct packed {
    logic        has_res; // Nop expects a quiet slot instead of a pulse
    logic [31:0] data;
    logic [7:0]  tuser;   // {seq, reg_idx, status}
    logic [31:0] due;     // Cycle count at which the pulse is sampled
    logic [15:0] idx;     // Table entry
  } expect_t;

  logic                   aclk;
  logic                   aresetn;
  logic [addr_width-1:0]  s_axi_awaddr;
  logic                   s_axi_awvalid;
  logic                   s_axi_awready;
  logic [data_width-1:0]  s_axi_wdata;
  logic                   s_axi_wvalid;
  logic                   s_axi_wready;
  logic [1:0]             s_axi_bresp;
  logic                   s_axi_bvalid;
  logic                   s_axi_bready;
  logic [addr_width-1:0]  s_axi_araddr;
  logic                   s_axi_arvalid;
  logic                   s_axi_arready;
  logic [data_width-1:0]  s_axi_rdata;
  logic [1:0]             s_axi_rresp;
  logic                   s_axi_rvalid;
  logic                   s_axi_rready;
  logic [data_width-1:0]  res_tdata;
  logic [tuser_width-1:0] res_tuser;
  logic                   res_tvalid;

  string       name_q[$];            // Stimulus table
  logic [31:0] word_q[$];
  int          delay_q[$];           // bready delay per command

  expect_t     exp_q[$];             // Results in flight
  logic [31:0] model_acc [num_regs]; // Reference accumulators
  logic [3:0]  model_seq;
  string       last_name;            // Most recently accepted test

  int cycle       = 0;
  int cycle_limit = 0;
  int done_count  = 0;
  int fail_count  = 0;
  int bus_errors  = 0;

  cmd_engine_top dut (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .res_tdata     (res_tdata),
    .res_tuser     (res_tuser),
    .res_tvalid    (res_tvalid)
  );

  initial
  begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk; // 4 ns period
  end

  // Delay of -1 picks a random 0 to 3
  // Reserved bits carry random noise
  task automatic add_entry(input string name, input logic [3:0] op, input logic [1:0] idx,
                           input logic [15:0] imm, input int delay);
    logic [9:0] rsvd;
    rsvd = 10'($urandom);
    name_q.push_back(name);
    word_q.push_back({op, idx, rsvd, imm});
    delay_q.push_back((delay < 0) ? int'($urandom_range(3, 0)) : delay);
  endtask

  task automatic build_table();
    add_entry("load_r0",           op_load, 2'd0, 16'h1234, 0);
    add_entry("load_r1",           op_load, 2'd1, 16'hbeef, 1);
    add_entry("load_r2",           op_load, 2'd2, 16'h0001, -1);
    add_entry("load_r3",           op_load, 2'd3, 16'hffff, 0);
    add_entry("read_r0",           op_read, 2'd0, 16'h0000, 0);
    add_entry("read_r1",           op_read, 2'd1, 16'h0000, 2);
    add_entry("read_r2",           op_read, 2'd2, 16'h0000, -1);
    add_entry("read_r3",           op_read, 2'd3, 16'h0000, 3);
    add_entry("add_r0",            op_add,  2'd0, 16'h0010, 0);
    add_entry("add_r3_carry",      op_add,  2'd3, 16'hffff, -1);
    add_entry("sub_r2_wrap",       op_sub,  2'd2, 16'h0005, 0);  // 1 - 5 wraps below zero
    add_entry("and_r1",            op_and,  2'd1, 16'h0f0f, 1);
    add_entry("xor_r1",            op_xor,  2'd1, 16'hffff, 3);
    add_entry("shl_r2_zero",       op_shl,  2'd2, 16'h0000, 0);
    add_entry("load_r2_one",       op_load, 2'd2, 16'h0001, -1);
    add_entry("shl_r2_31",         op_shl,  2'd2, 16'h001f, 0);
    add_entry("shl_r3_low_bits",   op_shl,  2'd3, 16'h0024, 2);  // Only imm[4:0] counts
    add_entry("illegal_8_r0",      4'd8,    2'd0, 16'h5555, 0);
    add_entry("illegal_11_r3",     4'd11,   2'd3, 16'h1234, -1);
    add_entry("illegal_15_r1",     4'd15,   2'd1, 16'haaaa, 3);
    add_entry("read_r0_after_ill", op_read, 2'd0, 16'h0000, 0);
    add_entry("read_r1_after_ill", op_read, 2'd1, 16'h0000, -1);
    add_entry("nop_r0",            op_nop,  2'd0, 16'h7777, 0);
    add_entry("nop_r2",            op_nop,  2'd2, 16'h0000, -1);
    add_entry("read_r2_after_nop", op_read, 2'd2, 16'h0000, 1);  // seq must not skip
    add_entry("read_r3_final",     op_read, 2'd3, 16'h0000, 0);
  endtask

  // Reference behavior taken from the command format rules
  task automatic model_command(input int i);
    logic [3:0]  op;
    logic [1:0]  idx;
    logic [31:0] imm;
    logic [31:0] cur;
    logic [31:0] val;
    logic [1:0]  st;
    expect_t     e;
    op  = word_q[i][31:28];
    idx = word_q[i][27:26];
    imm = {16'h0000, word_q[i][15:0]}; // Zero-extended
    cur = model_acc[idx];
    val = cur;
    st  = 2'd0;
    if (op >= 4'd8)
    begin
      st = 2'd1;                       // Illegal opcode leaves the register untouched
    end
    else
    begin
      case (op)
        op_load: val = imm;
        op_add:  val = cur + imm;
        op_sub:  val = cur - imm;
        op_and:  val = cur & imm;
        op_xor:  val = cur ^ imm;
        op_shl:  val = cur << imm[4:0];
        default: val = cur;            // Read and nop
      endcase
    end
    model_acc[idx] = val;
    e.has_res = (op != 4'd0);
    e.data    = val;
    e.tuser   = {model_seq, idx, st};
    e.due     = cycle + 3;             // Fixed latency from acceptance
    e.idx     = 16'(i);
    if (e.has_res)
    begin
      model_seq = model_seq + 4'd1;    // Wraps 15 to 0
    end
    exp_q.push_back(e);
  endtask

  task automatic present_cmd(input int i);
    s_axi_awaddr  <= addr_width'($urandom);
    s_axi_wdata   <= word_q[i];
    s_axi_awvalid <= 1'b1;             // Address and data together
    s_axi_wvalid  <= 1'b1;
    s_axi_araddr  <= addr_width'($urandom);
    s_axi_arvalid <= 1'b1;             // Read request that must stay unanswered
  endtask

  task automatic idle_bus();
    s_axi_awvalid <= 1'b0;
    s_axi_wvalid  <= 1'b0;
    s_axi_arvalid <= 1'b0;
  endtask

  // Next command is presented while the response is still pending
  task automatic run_table();
    int n;
    n = name_q.size();
    present_cmd(0);
    s_axi_bready <= (delay_q[0] == 0);
    for (int i = 0; i < n; i++)
    begin
      @(posedge aclk);
      while (!s_axi_awready)
      begin
        @(posedge aclk);
      end
      last_name = name_q[i];
      model_command(i);
      if (i + 1 < n)
      begin
        present_cmd(i + 1);
      end
      else
      begin
        idle_bus();
      end
      if (delay_q[i] > 0)
      begin
        repeat (delay_q[i]) @(posedge aclk);
        s_axi_bready <= 1'b1;
      end
      @(posedge aclk);
      while (!(s_axi_bvalid && s_axi_bready))
      begin
        @(posedge aclk);
      end
      if (i + 1 < n)
      begin
        s_axi_bready <= (delay_q[i+1] == 0); // Zero delay means ready in advance
      end
      else
      begin
        s_axi_bready <= 1'b0;
      end
    end
  endtask

  task automatic finish_test(input int idx, input logic ok);
    done_count++;
    if (!ok)
    begin
      fail_count++;
    end
    $display("Test %-20s %s", name_q[idx], ok ? "ok" : "FAIL");
  endtask

  task automatic check_bus();
    assert (s_axi_awready === s_axi_wready) else
    begin
      $display("Address and data ready did not rise together during %s", last_name);
      bus_errors++;
    end
    assert (s_axi_arready === 1'b0 && s_axi_rvalid === 1'b0) else
    begin
      $display("The tied-off read channel answered a request during %s", last_name);
      bus_errors++;
    end
    assert (s_axi_rdata === '0) else
    begin
      $display("Error: %s rdata expected 32'h00000000, actual 32'h%08h",
               last_name, s_axi_rdata);
      bus_errors++;
    end
    assert (s_axi_rresp === 2'b00) else
    begin
      $display("Error: %s rresp expected 2'b00, actual 2'b%02b", last_name, s_axi_rresp);
      bus_errors++;
    end
    if (s_axi_bvalid)
    begin
      assert (!s_axi_awready && !s_axi_wready) else
      begin
        $display("A write was accepted while the response for %s was still pending", last_name);
        bus_errors++;
      end
      assert (s_axi_bresp == 2'b00) else
      begin
        $display("Error: %s bresp expected 2'b00, actual 2'b%02b", last_name, s_axi_bresp);
        bus_errors++;
      end
    end
  endtask

  task automatic check_result();
    expect_t e;
    logic    ok;
    if (exp_q.size() != 0 && exp_q[0].due == cycle)
    begin
      e  = exp_q.pop_front();
      ok = 1'b1;
      if (e.has_res)
      begin
        assert (res_tvalid) else
        begin
          $display("Test %s never produced its result in cycle %0d", name_q[e.idx], cycle);
          ok = 1'b0;
        end
        if (res_tvalid)
        begin
          assert (res_tdata === e.data) else
          begin
            $display("Error: %s data expected 32'h%08h, actual 32'h%08h",
                     name_q[e.idx], e.data, res_tdata);
            ok = 1'b0;
          end
          assert (res_tuser === e.tuser) else
          begin
            $display("Error: %s tuser expected 8'h%02h, actual 8'h%02h",
                     name_q[e.idx], e.tuser, res_tuser);
            ok = 1'b0;
          end
        end
      end
      else
      begin
        assert (!res_tvalid) else
        begin
          $display("Test %s is a nop but a result pulse appeared", name_q[e.idx]);
          ok = 1'b0;
        end
      end
      finish_test(e.idx, ok);
    end
    else
    begin
      assert (!res_tvalid) else
      begin
        $display("A result pulse arrived in cycle %0d with no result due", cycle);
        bus_errors++;
      end
    end
  endtask

  always @(posedge aclk)
  begin
    cycle <= cycle + 1;                  // Read by everyone as the pre-edge count
    if (aresetn)
    begin
      check_bus();
      check_result();
    end
  end

  initial
  begin
    wait (cycle_limit > 0);
    while (cycle < cycle_limit)
    begin
      @(posedge aclk);
    end
    $display("Timeout after %0d cycles, %0d results still pending", cycle, exp_q.size());
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    void'($urandom(79763));
    aresetn       = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;                // Read channel idle until the first command
    s_axi_rready  = 1'b0;
    model_seq     = 4'd0;
    last_name     = "idle";
    for (int r = 0; r < num_regs; r++)
    begin
      model_acc[r] = 32'h0;              // Accumulators clear on reset
    end
    build_table();
    cycle_limit = name_q.size() * 12 + 100;
    repeat (5) @(posedge aclk);
    aresetn <= 1'b1;
    @(posedge aclk);
    run_table();
    while (exp_q.size() != 0)
    begin
      @(posedge aclk);
    end
    repeat (4) @(posedge aclk);          // Catch stray pulses
    $display("Tests %0d of %0d done, %0d failed, %0d bus errors",
             done_count, name_q.size(), fail_count, bus_errors);
    if (fail_count == 0 && bus_errors == 0 && done_count == name_q.size())
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* project.f */
cmd_pkg.sv
axi_axis_writer.sv
cmd_decode.sv
accum_execute.sv
result_pack.sv
cmd_engine_top.sv
tb_cmd_engine.sv

/* Bender.yml */
package:
  name: cmd_engine

sources:
  - cmd_pkg.sv
  - axi_axis_writer.sv
  - cmd_decode.sv
  - accum_execute.sv
  - result_pack.sv
  - cmd_engine_top.sv
  - target: test
    files:
      - tb_cmd_engine.sv
